//--- hw/boardRenderer.sv
`timescale 1ns/100ps
`default_nettype none

module boardRenderer (
	input  logic Clk,
	input  logic Reset,
	input  logic [connectFourPkg::CounterWidth-1:0] pixelX,
	input  logic [connectFourPkg::CounterWidth-1:0] pixelY,
	input  logic [connectFourPkg::CellCount-1:0] board,
	input  logic [connectFourPkg::CellCount-1:0] colors,
	output logic [connectFourPkg::ColorCodeWidth-1:0] boardColor
);

	logic [connectFourPkg::ColorCodeWidth-1:0] colorNext;
	logic colHit;
	logic rowHit;
	logic inBoard;
	int colIdx;
	int rowIdx;
	int cellIdx;

	assign inBoard = pixelX >= connectFourPkg::BoardLeft &&
		pixelX <= connectFourPkg::BoardRight &&
		pixelY >= connectFourPkg::BoardTop &&
		pixelY <= connectFourPkg::BoardBottom;

	// Squares never overlap, so at most one column matches
	always_comb
	begin
		int centerX;
		colHit = 1'b0;
		colIdx = 0;
		for (int c = 0; c < connectFourPkg::ColCount; c++)
		begin
			centerX = connectFourPkg::XFirstCenter + c * connectFourPkg::CellPitch;
			if (pixelX >= centerX - connectFourPkg::ChipHalf &&
				pixelX <= centerX + connectFourPkg::ChipHalf)
			begin
				colHit = 1'b1;
				colIdx = c;
			end
		end
	end

	// Row 0 sits at the bottom
	always_comb
	begin
		int centerY;
		rowHit = 1'b0;
		rowIdx = 0;
		for (int r = 0; r < connectFourPkg::RowCount; r++)
		begin
			centerY = connectFourPkg::YBottomCenter - r * connectFourPkg::CellPitch;
			if (pixelY >= centerY - connectFourPkg::ChipHalf &&
				pixelY <= centerY + connectFourPkg::ChipHalf)
			begin
				rowHit = 1'b1;
				rowIdx = r;
			end
		end
	end

	assign cellIdx = rowIdx * connectFourPkg::ColCount + colIdx;

	always_comb
	begin
		colorNext = connectFourPkg::ColorWhite;
		if (inBoard)
			colorNext = connectFourPkg::ColorYellow;
		if (colHit && rowHit)
		begin
			if (!board[cellIdx])
				colorNext = connectFourPkg::ColorWhite; // Empty slot
			else if (colors[cellIdx])
				colorNext = connectFourPkg::ColorBlack;
			else
				colorNext = connectFourPkg::ColorRed;
		end
	end

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
			boardColor <= connectFourPkg::ColorWhite;
		else
			boardColor <= colorNext;
	end

endmodule

`default_nettype wire

//--- hw/connectFourDisplay.sv
`timescale 1ns/100ps
`default_nettype none

module connectFourDisplay (
	input  logic Clk,
	input  logic Reset,
	input  logic [connectFourPkg::CellCount-1:0] board,
	input  logic [connectFourPkg::CellCount-1:0] colors,
	input  logic [connectFourPkg::ColWidth-1:0] selectedCol,
	input  logic player,
	input  logic startState,
	input  logic endState,
	output logic vgaHsync,
	output logic vgaVsync,
	output logic [2:0] vgaRed,
	output logic [2:0] vgaGreen,
	output logic [1:0] vgaBlue
);

	logic [connectFourPkg::CounterWidth-1:0] pixelX;
	logic [connectFourPkg::CounterWidth-1:0] pixelY;
	logic hSyncRaw;
	logic vSyncRaw;
	logic displayArea;
	logic [connectFourPkg::ColorCodeWidth-1:0] boardColor;
	logic [connectFourPkg::ColorCodeWidth-1:0] chipColor;
	logic chipHit;

	vgaSyncGen syncGen (
		.Clk         (Clk),
		.Reset       (Reset),
		.pixelX      (pixelX),
		.pixelY      (pixelY),
		.hSyncRaw    (hSyncRaw),
		.vSyncRaw    (vSyncRaw),
		.displayArea (displayArea)
	);

	boardRenderer boardLayer (
		.Clk        (Clk),
		.Reset      (Reset),
		.pixelX     (pixelX),
		.pixelY     (pixelY),
		.board      (board),
		.colors     (colors),
		.boardColor (boardColor)
	);

	// Banner layer, one cycle like the board
	turnChipRenderer chipLayer (
		.Clk         (Clk),
		.Reset       (Reset),
		.pixelX      (pixelX),
		.pixelY      (pixelY),
		.selectedCol (selectedCol),
		.player      (player),
		.startState  (startState),
		.endState    (endState),
		.chipHit     (chipHit),
		.chipColor   (chipColor)
	);

	pixelCombiner combiner (
		.Clk         (Clk),
		.Reset       (Reset),
		.boardColor  (boardColor),
		.chipHit     (chipHit),
		.chipColor   (chipColor),
		.hSyncRaw    (hSyncRaw),
		.vSyncRaw    (vSyncRaw),
		.displayArea (displayArea),
		.vgaHsync    (vgaHsync),
		.vgaVsync    (vgaVsync),
		.vgaRed      (vgaRed),
		.vgaGreen    (vgaGreen),
		.vgaBlue     (vgaBlue)
	);

endmodule

`default_nettype wire

//--- hw/connectFourPkg.sv
`default_nettype none

package connectFourPkg;

	// 640x480 raster, pixel counts per line
	localparam int HVisible   = 640;
	localparam int HSyncStart = 656;
	localparam int HSyncEnd   = 751; // Last low pixel
	localparam int HTotal     = 800;

	// Line counts per frame
	localparam int VVisible   = 480;
	localparam int VSyncStart = 490;
	localparam int VSyncEnd   = 491;
	localparam int VTotal     = 525;

	localparam int CounterWidth = 10;

	// Board layout
	localparam int ColCount  = 7;
	localparam int RowCount  = 6;
	localparam int CellCount = 42; // Index is row * 7 + col

	localparam int ColorCodeWidth = 2;
	localparam int ColWidth       = 3;

	// Chip centres, rows count upward from the bottom
	localparam int XFirstCenter  = 125;
	localparam int YBottomCenter = 442;
	localparam int CellPitch     = 65;
	localparam int ChipHalf      = 27;

	// Yellow board, inclusive bounds
	localparam int BoardLeft   = 88;
	localparam int BoardRight  = 551;
	localparam int BoardTop    = 80;
	localparam int BoardBottom = 479;

	// Strip holding the preview chip
	localparam int BannerTop    = 13;
	localparam int BannerBottom = 67;

	localparam logic [ColorCodeWidth-1:0] ColorWhite  = 2'd0;
	localparam logic [ColorCodeWidth-1:0] ColorRed    = 2'd1;
	localparam logic [ColorCodeWidth-1:0] ColorBlack  = 2'd2;
	localparam logic [ColorCodeWidth-1:0] ColorYellow = 2'd3;

	// Pin order red2 red1 red0 green2 green1 green0 blue1 blue0
	localparam logic [7:0] PinsWhite  = 8'b111_111_11;
	localparam logic [7:0] PinsRed    = 8'b110_000_00;
	localparam logic [7:0] PinsBlack  = 8'b000_000_00;
	localparam logic [7:0] PinsYellow = 8'b101_101_00;

endpackage

`default_nettype wire

//--- hw/pixelCombiner.sv
`timescale 1ns/100ps
`default_nettype none

module pixelCombiner (
	input  logic Clk,
	input  logic Reset,
	input  logic [connectFourPkg::ColorCodeWidth-1:0] boardColor,
	input  logic chipHit,
	input  logic [connectFourPkg::ColorCodeWidth-1:0] chipColor,
	input  logic hSyncRaw,
	input  logic vSyncRaw,
	input  logic displayArea,
	output logic vgaHsync,
	output logic vgaVsync,
	output logic [2:0] vgaRed,
	output logic [2:0] vgaGreen,
	output logic [1:0] vgaBlue
);

	logic [connectFourPkg::ColorCodeWidth-1:0] finalColor;
	logic [7:0] pinsNext;
	logic [7:0] pins;
	logic [1:0] hSyncPipe;
	logic [1:0] vSyncPipe;
	logic [1:0] areaPipe;

	assign finalColor = chipHit ? chipColor : boardColor; // Chip on top

	always_comb
	begin
		unique case (finalColor)
			connectFourPkg::ColorWhite:  pinsNext = connectFourPkg::PinsWhite;
			connectFourPkg::ColorRed:    pinsNext = connectFourPkg::PinsRed;
			connectFourPkg::ColorBlack:  pinsNext = connectFourPkg::PinsBlack;
			connectFourPkg::ColorYellow: pinsNext = connectFourPkg::PinsYellow;
		endcase
	end

	// Layers lag the raw syncs by one cycle, so the first stage
	// of the area flag is the one that matches them
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			hSyncPipe <= 2'b11;
			vSyncPipe <= 2'b11;
			areaPipe  <= 2'b00;
			pins      <= '0;
		end
		else
		begin
			hSyncPipe <= {hSyncPipe[0], hSyncRaw};
			vSyncPipe <= {vSyncPipe[0], vSyncRaw};
			areaPipe  <= {areaPipe[0], displayArea};
			pins      <= areaPipe[0] ? pinsNext : '0;
		end
	end

	assign vgaHsync = hSyncPipe[1];
	assign vgaVsync = vSyncPipe[1];
	assign {vgaRed, vgaGreen, vgaBlue} = pins;

	blankPins: assert property (@(posedge Clk) disable iff (Reset)
		!areaPipe[1] |-> pins == '0)
		else $error("Pins active during blanking: %h", pins);

endmodule

`default_nettype wire

//--- hw/turnChipRenderer.sv
`timescale 1ns/100ps
`default_nettype none

module turnChipRenderer (
	input  logic Clk,
	input  logic Reset,
	input  logic [connectFourPkg::CounterWidth-1:0] pixelX,
	input  logic [connectFourPkg::CounterWidth-1:0] pixelY,
	input  logic [connectFourPkg::ColWidth-1:0] selectedCol,
	input  logic player,
	input  logic startState,
	input  logic endState,
	output logic chipHit,
	output logic [connectFourPkg::ColorCodeWidth-1:0] chipColor
);

	logic inBanner;
	logic inColumn;
	logic colValid;
	logic hitNext;
	int centerX;

	assign inBanner = pixelY >= connectFourPkg::BannerTop &&
		pixelY <= connectFourPkg::BannerBottom;

	assign colValid = selectedCol < connectFourPkg::ColCount; // 7 means none
	assign centerX  = connectFourPkg::XFirstCenter +
		int'(selectedCol) * connectFourPkg::CellPitch;
	assign inColumn = pixelX >= centerX - connectFourPkg::ChipHalf &&
		pixelX <= centerX + connectFourPkg::ChipHalf;

	// Hidden while the start or end screen is up
	assign hitNext = inBanner && colValid && inColumn && !startState && !endState;

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			chipHit   <= 1'b0;
			chipColor <= connectFourPkg::ColorRed;
		end
		else
		begin
			chipHit   <= hitNext;
			chipColor <= player ? connectFourPkg::ColorBlack : connectFourPkg::ColorRed;
		end
	end

	// Registered hit must come from a banner row one cycle earlier
	hitInBanner: assert property (@(posedge Clk) disable iff (Reset)
		chipHit |-> $past(pixelY) >= connectFourPkg::BannerTop &&
			$past(pixelY) <= connectFourPkg::BannerBottom)
		else $error("Preview chip outside banner rows");

endmodule

`default_nettype wire

//--- hw/vgaSyncGen.sv
`timescale 1ns/100ps
`default_nettype none

module vgaSyncGen (
	input  logic Clk,
	input  logic Reset,
	output logic [connectFourPkg::CounterWidth-1:0] pixelX,
	output logic [connectFourPkg::CounterWidth-1:0] pixelY,
	output logic hSyncRaw,
	output logic vSyncRaw,
	output logic displayArea
);

	logic [connectFourPkg::CounterWidth-1:0] xNext;
	logic [connectFourPkg::CounterWidth-1:0] yNext;
	logic lineEnd;
	logic frameEnd;

	assign lineEnd  = (pixelX == connectFourPkg::HTotal - 1);
	assign frameEnd = (pixelY == connectFourPkg::VTotal - 1);

	// Next raster position
	always_comb
	begin
		xNext = lineEnd ? '0 : pixelX + 1'b1;
		yNext = pixelY;
		if (lineEnd)
		begin
			if (frameEnd)
				yNext = '0;
			else
				yNext = pixelY + 1'b1;
		end
	end

	// Syncs and flag are decoded from the next position,
	// so they line up with the counters they describe
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			pixelX      <= '0;
			pixelY      <= '0;
			hSyncRaw    <= 1'b1;
			vSyncRaw    <= 1'b1;
			displayArea <= 1'b1; // Position 0,0 is visible
		end
		else
		begin
			pixelX      <= xNext;
			pixelY      <= yNext;
			hSyncRaw    <= !(xNext >= connectFourPkg::HSyncStart &&
				xNext <= connectFourPkg::HSyncEnd);
			vSyncRaw    <= !(yNext >= connectFourPkg::VSyncStart &&
				yNext <= connectFourPkg::VSyncEnd);
			displayArea <= (xNext < connectFourPkg::HVisible) &&
				(yNext < connectFourPkg::VVisible);
		end
	end

	xInRange: assert property (@(posedge Clk) disable iff (Reset)
		pixelX < connectFourPkg::HTotal)
		else $error("pixelX out of range: %0d", pixelX);

	yInRange: assert property (@(posedge Clk) disable iff (Reset)
		pixelY < connectFourPkg::VTotal)
		else $error("pixelY out of range: %0d", pixelY);

endmodule

`default_nettype wire

//--- sim.f
hw/connectFourPkg.sv
hw/vgaSyncGen.sv
hw/boardRenderer.sv
hw/turnChipRenderer.sv
hw/pixelCombiner.sv
hw/connectFourDisplay.sv
test/displayChecker.sv
test/tbConnectFourDisplay.sv

//--- test/displayChecker.sv
`timescale 1ns/100ps
`default_nettype none

module displayChecker (
	input  logic Clk,
	input  logic Reset,
	input  logic [connectFourPkg::CellCount-1:0] board,
	input  logic [connectFourPkg::CellCount-1:0] colors,
	input  logic [connectFourPkg::ColWidth-1:0] selectedCol,
	input  logic player,
	input  logic startState,
	input  logic endState,
	input  logic vgaHsync,
	input  logic vgaVsync,
	input  logic [2:0] vgaRed,
	input  logic [2:0] vgaGreen,
	input  logic [1:0] vgaBlue,
	output int errorCount,
	output int pixelCount,
	output int syncCount
);

	logic prevH;
	logic prevV;
	logic locked;
	int x; // Raster position of the current sample
	int y;
	int hLow;
	int hPeriod;
	int vLow;
	int vPeriod;
	bit hStarted;
	bit vStarted;
	int cycleErrors;
	int cycleSyncs;

	// Expected pins from the screen rules
	function automatic logic [7:0] expectedPins(int px, int py,
		logic [connectFourPkg::CellCount-1:0] brd, logic [connectFourPkg::CellCount-1:0] clr,
		int col, logic plr, logic st, logic en);
		logic [1:0] code;
		int relX;
		int relY;
		int idx;
		int chipLeft;
		if (px >= connectFourPkg::HVisible || py >= connectFourPkg::VVisible)
			return 8'h00;
		code = connectFourPkg::ColorWhite;
		if (px >= connectFourPkg::BoardLeft && px <= connectFourPkg::BoardRight &&
			py >= connectFourPkg::BoardTop && py <= connectFourPkg::BoardBottom)
			code = connectFourPkg::ColorYellow;
		// Offsets from the left edge of column 0 and the bottom edge of row 0
		relX = px - (connectFourPkg::XFirstCenter - connectFourPkg::ChipHalf);
		relY = (connectFourPkg::YBottomCenter + connectFourPkg::ChipHalf) - py;
		if (relX >= 0 && relY >= 0 && relX % connectFourPkg::CellPitch <= 2 * connectFourPkg::ChipHalf &&
			relY % connectFourPkg::CellPitch <= 2 * connectFourPkg::ChipHalf &&
			relX / connectFourPkg::CellPitch < connectFourPkg::ColCount &&
			relY / connectFourPkg::CellPitch < connectFourPkg::RowCount)
		begin
			idx = (relY / connectFourPkg::CellPitch) * connectFourPkg::ColCount +
				relX / connectFourPkg::CellPitch;
			if (!brd[idx])
				code = connectFourPkg::ColorWhite;
			else
				code = clr[idx] ? connectFourPkg::ColorBlack : connectFourPkg::ColorRed;
		end
		chipLeft = connectFourPkg::XFirstCenter + col * connectFourPkg::CellPitch - connectFourPkg::ChipHalf;
		if (py >= connectFourPkg::BannerTop && py <= connectFourPkg::BannerBottom &&
			col < connectFourPkg::ColCount && !st && !en &&
			px >= chipLeft && px <= chipLeft + 2 * connectFourPkg::ChipHalf)
			code = plr ? connectFourPkg::ColorBlack : connectFourPkg::ColorRed;
		case (code)
			connectFourPkg::ColorRed:    return connectFourPkg::PinsRed;
			connectFourPkg::ColorBlack:  return connectFourPkg::PinsBlack;
			connectFourPkg::ColorYellow: return connectFourPkg::PinsYellow;
			default:                     return connectFourPkg::PinsWhite;
		endcase
	endfunction

	task automatic compareValue(input string name, input int expected, input int observed);
		if (expected != observed)
		begin
			if (errorCount + cycleErrors < 20) // Keep the log readable
				$display("Mismatch %s expected %h observed %h x %h y %h",
					name, expected, observed, x, y);
			cycleErrors++;
		end
	endtask

	task automatic measureSync(input string name, input int expected, input int observed);
		cycleSyncs++;
		compareValue(name, expected, observed);
	endtask

	always @(posedge Clk)
	begin
		logic [7:0] pinsExp;
		cycleErrors = 0;
		cycleSyncs = 0;
		if (Reset)
		begin
			locked = 1'b0;
			prevH = 1'b1;
			prevV = 1'b1;
			hStarted = 1'b0;
			vStarted = 1'b0;
			errorCount <= 0;
			pixelCount <= 0;
			syncCount <= 0;
		end
		else
		begin
			if (locked)
			begin
				if (x == connectFourPkg::HTotal - 1)
				begin
					x = 0;
					y = (y == connectFourPkg::VTotal - 1) ? 0 : y + 1;
				end
				else
					x++;
			end
			hPeriod++;
			vPeriod++;
			if (prevH && !vgaHsync)
			begin
				if (locked)
					compareValue("hsyncFallX", connectFourPkg::HSyncStart, x);
				x = connectFourPkg::HSyncStart;
				if (hStarted)
					measureSync("hsyncPeriod", connectFourPkg::HTotal, hPeriod);
				hStarted = 1'b1;
				hPeriod = 0;
				hLow = 0;
			end
			if (!prevH && vgaHsync && hStarted)
				measureSync("hsyncLowClocks", connectFourPkg::HSyncEnd - connectFourPkg::HSyncStart + 1,
					hLow);
			if (prevV && !vgaVsync)
			begin
				if (locked)
					compareValue("vsyncFallY", connectFourPkg::VSyncStart, y);
				x = 0; // Vsync falls at the start of its line
				y = connectFourPkg::VSyncStart;
				locked = 1'b1;
				if (vStarted)
					measureSync("framePeriod", connectFourPkg::VTotal * connectFourPkg::HTotal, vPeriod);
				vStarted = 1'b1;
				vPeriod = 0;
				vLow = 0;
			end
			if (!prevV && vgaVsync && vStarted)
				measureSync("vsyncLowClocks",
					(connectFourPkg::VSyncEnd - connectFourPkg::VSyncStart + 1) * connectFourPkg::HTotal, vLow);
			if (!vgaHsync)
				hLow++;
			if (!vgaVsync)
				vLow++;
			if (locked)
			begin
				pinsExp = expectedPins(x, y, board, colors, int'(selectedCol), player, startState, endState);
				compareValue("vgaRed", pinsExp[7:5], vgaRed);
				compareValue("vgaGreen", pinsExp[4:2], vgaGreen);
				compareValue("vgaBlue", pinsExp[1:0], vgaBlue);
				pixelCount <= pixelCount + 1;
			end
			prevH = vgaHsync;
			prevV = vgaVsync;
			errorCount <= errorCount + cycleErrors;
			syncCount <= syncCount + cycleSyncs;
		end
	end

endmodule

`default_nettype wire

//--- test/tbConnectFourDisplay.sv
`timescale 1ns/100ps
`default_nettype none

module tbConnectFourDisplay;

	logic Clk;
	logic Reset;
	logic [connectFourPkg::CellCount-1:0] board;
	logic [connectFourPkg::CellCount-1:0] colors;
	logic [connectFourPkg::ColWidth-1:0] selectedCol;
	logic player;
	logic startState;
	logic endState;
	logic vgaHsync;
	logic vgaVsync;
	logic [2:0] vgaRed;
	logic [2:0] vgaGreen;
	logic [1:0] vgaBlue;
	int errorCount;
	int pixelCount;
	int syncCount;
	int seed;
	int testCount;
	int failedTests;
	bit timedOut;

	always #20 Clk = ~Clk;

	connectFourDisplay u_dut (.Clk(Clk), .Reset(Reset), .board(board), .colors(colors),
		.selectedCol(selectedCol), .player(player), .startState(startState), .endState(endState),
		.vgaHsync(vgaHsync), .vgaVsync(vgaVsync), .vgaRed(vgaRed), .vgaGreen(vgaGreen),
		.vgaBlue(vgaBlue));

	displayChecker u_check (.Clk(Clk), .Reset(Reset), .board(board), .colors(colors),
		.selectedCol(selectedCol), .player(player), .startState(startState), .endState(endState),
		.vgaHsync(vgaHsync), .vgaVsync(vgaVsync), .vgaRed(vgaRed), .vgaGreen(vgaGreen),
		.vgaBlue(vgaBlue), .errorCount(errorCount), .pixelCount(pixelCount), .syncCount(syncCount));

	task automatic waitVsyncFall(output bit ok);
		logic prev;
		int cycles;
		prev = vgaVsync;
		ok = 1'b0;
		cycles = 0;
		while (!ok && cycles < 900000)
		begin
			@(posedge Clk);
			ok = prev && !vgaVsync;
			prev = vgaVsync;
			cycles++;
		end
		if (!ok)
		begin
			timedOut = 1'b1;
			$display("Timeout: vsync did not fall within 900000 cycles");
		end
	endtask

	task automatic drawRandom(output logic [connectFourPkg::CellCount-1:0] brd,
		output logic [connectFourPkg::CellCount-1:0] clr, output logic [2:0] col, output logic plr);
		logic [63:0] wide;
		logic [31:0] pick;
		wide = {$random(seed), $random(seed)};
		brd = wide[connectFourPkg::CellCount-1:0];
		wide = {$random(seed), $random(seed)};
		clr = wide[connectFourPkg::CellCount-1:0];
		pick = $random(seed);
		col = 3'(pick % 7); // Columns 0 to 6 only
		plr = pick[16];
	endtask

	// Inputs change just after a vsync edge, deep in vertical blanking
	task automatic setInputs(input logic [connectFourPkg::CellCount-1:0] brd,
		input logic [connectFourPkg::CellCount-1:0] clr, input logic [2:0] col,
		input logic plr, input logic st, input logic en);
		#2;
		board = brd;
		colors = clr;
		selectedCol = col;
		player = plr;
		startState = st;
		endState = en;
	endtask

	task automatic runFrame(input string name, input bit needSync);
		int errBefore;
		int pixBefore;
		int syncBefore;
		bit ok;
		bit passed;
		errBefore = errorCount;
		pixBefore = pixelCount;
		syncBefore = syncCount;
		testCount++;
		if (timedOut)
			ok = 1'b0;
		else
			waitVsyncFall(ok);
		passed = ok && errorCount == errBefore && pixelCount > pixBefore &&
			(!needSync || syncCount > syncBefore);
		if (!passed)
			failedTests++;
		$display("Test %0d %s: %s, %0d pixels, %0d sync measurements, %0d errors", testCount,
			name, passed ? "pass" : "fail", pixelCount - pixBefore, syncCount - syncBefore,
			errorCount - errBefore);
	endtask

	initial
	begin
		logic [connectFourPkg::CellCount-1:0] rb;
		logic [connectFourPkg::CellCount-1:0] rc;
		logic [2:0] rcol;
		logic rp;
		bit ok;
		seed = 65323;
		Clk = 1'b0;
		Reset = 1'b1;
		board = '0;
		colors = '0;
		selectedCol = '0;
		player = 1'b0;
		startState = 1'b1;
		endState = 1'b0;
		testCount = 0;
		failedTests = 0;
		timedOut = 1'b0;
		repeat (8) @(posedge Clk);
		#2 Reset = 1'b0;
		waitVsyncFall(ok); // Checker locks here

		setInputs('0, '0, 3'd0, 1'b0, 1'b1, 1'b0);
		runFrame("sync timing", 1'b1);
		drawRandom(rb, rc, rcol, rp);
		setInputs('0, rc, rcol, rp, 1'b1, 1'b0);
		runFrame("empty board", 1'b0);
		drawRandom(rb, rc, rcol, rp);
		setInputs(rb, rc, rcol, rp, 1'b1, 1'b0);
		runFrame("random board", 1'b0);
		drawRandom(rb, rc, rcol, rp);
		setInputs(rb, rc, rcol, 1'b0, 1'b0, 1'b0);
		runFrame("preview chip red", 1'b0);
		drawRandom(rb, rc, rcol, rp);
		setInputs(rb, rc, rcol, 1'b1, 1'b0, 1'b0);
		runFrame("preview chip black", 1'b0);
		drawRandom(rb, rc, rcol, rp);
		setInputs(rb, rc, rcol, rp, 1'b1, 1'b0);
		runFrame("chip hidden at start", 1'b0);
		drawRandom(rb, rc, rcol, rp);
		setInputs(rb, rc, rcol, rp, 1'b0, 1'b1);
		runFrame("chip hidden at end", 1'b0);

		#2; // Let the last checker counts settle
		$display("Tests %0d, failed %0d, pixels %0d, errors %0d", testCount, failedTests,
			pixelCount, errorCount);
		if (!timedOut && failedTests == 0 && errorCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire
